// File: Makefile
# Verilator lint and simulation of the audio mixer

VERILATOR ?= verilator
FILE_LIST ?= files.f
TB_TOP    ?= audio_mix_tb
RTL_TOP   ?= audio_mix_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
RTL_SRC := $(filter hw/%,$(SOURCES))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRC)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILE_LIST)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) \
		-f $(FILE_LIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/audio_mix_tb.sv
// Default compressor parameters only; options are rewritten only while no frame is in flight
`default_nettype none

module audio_mix_tb;

	import audio_pkg::*;

	typedef struct packed {
		logic [31:0] cycle;
		sample_t     left;
		sample_t     right;
	} expect_t;

	// Frames over all tests, each given four cycles, plus register traffic
	localparam int N_FRAMES   = 300 + 3 * 150 + 2 * 150 + 200;
	localparam int MAX_CYCLES = 4 * N_FRAMES + 1000;

	// Knee and offset of the default curves
	localparam int KNEE_2X = 14043;
	localparam int OFFS_2X = 28086;
	localparam int KNEE_4X = 7399;
	localparam int OFFS_4X = 29596;

	logic        clk_sys;
	logic        reset;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	src_frame_t  src;
	out_frame_t  out;

	audio_cfg_t  cur_cfg;
	expect_t     pending[$];
	logic [31:0] cycle_count;
	string       test_name;

	audio_mix_top i_dut (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.src     (src),
		.out     (out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic end_in_failure();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			end_in_failure();
		end
	endtask

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", MAX_CYCLES);
			end_in_failure();
		end
	end

	////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////

	function automatic int wrap18(input int v);
		sum_t t;
		t = sum_t'(v);
		return int'(t);
	endfunction

	// Soft knee on the magnitude, sign restored afterwards
	function automatic sample_t shape(input int v, input logic [1:0] mode);
		int mag;
		int knee;
		int offs;
		int factor;
		int gain;
		int r;
		if (mode == 2'd0) begin
			return sample_t'(v);
		end
		knee   = (mode == 2'd1) ? KNEE_2X : KNEE_4X;
		offs   = (mode == 2'd1) ? OFFS_2X : OFFS_4X;
		factor = (mode == 2'd1) ? 4 : 8;
		gain   = (mode == 2'd1) ? 2 : 4;
		mag = (v < 0) ? -v : v;
		r = (mag < knee) ? mag * gain : (mag - knee) / factor + offs;
		r = r & 'hFFFF;
		return sample_t'((v < 0) ? -r : r);
	endfunction

	function automatic sample_t channel_reference(input int cd, input int psg, input int adp,
			input audio_cfg_t c);
		int pre;
		int lvl;
		pre = wrap18(cd + (c.cd_boost ? cd : 0) + psg + adp);
		lvl = c.cd_boost ? pre : wrap18(pre + (pre >>> 2));
		return shape(lvl >>> 2, c.master);
	endfunction

	function automatic expect_t mix_reference(input src_frame_t f, input audio_cfg_t c,
			input logic [31:0] cycle);
		int adp;
		expect_t e;
		adp = int'(f.adpcm) + (c.adpcm_boost ? (int'(f.adpcm) >>> 2) : 0);
		e.cycle = cycle;
		e.left  = channel_reference(int'(f.cd_left), int'(f.psg_left), adp, c);
		e.right = channel_reference(int'(f.cd_right), int'(f.psg_right), adp, c);
		return e;
	endfunction

	// Output side, sampled on the falling edge where out is settled
	always @(negedge clk_sys) begin
		expect_t e;
		if (!reset && out.valid) begin
			if (pending.size() == 0) begin
				$display("Error: output valid while no frame was expected");
				end_in_failure();
			end else begin
				e = pending.pop_front();
				check_value({test_name, " latency"}, e.cycle + 4, cycle_count);
				check_value({test_name, " left"}, 32'(e.left), 32'(out.left));
				check_value({test_name, " right"}, 32'(e.right), 32'(out.right));
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	// Full scale now and then so the sums wrap
	function automatic sample_t random_sample();
		case (3'($urandom))
			3'd0:    return sample_t'(16'h8000);
			3'd1:    return sample_t'(16'h7fff);
			default: return sample_t'($urandom);
		endcase
	endfunction

	function automatic src_frame_t random_frame(input logic valid);
		src_frame_t f;
		f.valid     = valid;
		f.cd_left   = random_sample();
		f.cd_right  = random_sample();
		f.psg_left  = random_sample();
		f.psg_right = random_sample();
		f.adpcm     = random_sample();
		return f;
	endfunction

	// With CD boost only, base = cd / 2, so left gets +base and right -base
	function automatic src_frame_t knee_frame(input int base);
		src_frame_t f;
		f = '0;
		f.valid    = 1'b1;
		f.cd_left  = sample_t'(2 * base);
		f.cd_right = sample_t'(-2 * base);
		return f;
	endfunction

	function automatic src_frame_t full_frame(input sample_t s);
		return '{valid: 1'b1, cd_left: s, cd_right: s, psg_left: s, psg_right: s, adpcm: s};
	endfunction

	task automatic drive_frame(input src_frame_t f);
		@(negedge clk_sys);
		src = f;
		if (f.valid) begin
			pending.push_back(mix_reference(f, cur_cfg, cycle_count));
		end
	endtask

	task automatic wait_drained();
		while (pending.size() != 0) begin
			@(negedge clk_sys);
		end
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic run_random(input string name, input int count, input logic sparse);
		test_name = name;
		repeat (count) drive_frame(random_frame(sparse ? 1'($urandom) : 1'b1));
		drive_frame('0);
		wait_drained();
	endtask

	// Every source at full scale of either sign
	task automatic drive_extremes();
		drive_frame(full_frame(sample_t'(16'h7fff)));
		drive_frame(full_frame(sample_t'(16'h8000)));
	endtask

	// Both knees at -1, 0 and +1, then the extremes
	task automatic drive_knees();
		for (int k = 0; k < 2; k++) begin
			for (int d = -1; d <= 1; d++) begin
				drive_frame(knee_frame(((k == 0) ? KNEE_2X : KNEE_4X) + d));
			end
		end
		drive_extremes();
	endtask

	task automatic access_reg(input logic we, input logic [2:0] adr, input logic [31:0] data,
			output logic [31:0] rdata);
		int waited;
		@(negedge clk_sys);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: data};
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!wb_rsp.ack && waited < 8);
		if (!wb_rsp.ack) begin
			$display("Error: no Wishbone acknowledge within 8 cycles");
			end_in_failure();
		end
		rdata = wb_rsp.dat_r;
		wb_req = '0;
		@(negedge clk_sys);
		check_value("single ack cycle", 32'd0, 32'(wb_rsp.ack));
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [31:0] data);
		logic [31:0] unused_rd;
		access_reg(1'b1, adr, data, unused_rd);
	endtask

	task automatic read_reg(input logic [2:0] adr, output logic [31:0] data);
		access_reg(1'b0, adr, 32'd0, data);
	endtask

	task automatic apply_config(input audio_cfg_t c);
		wait_drained();
		write_reg(3'd0, {28'd0, c.master, c.adpcm_boost, c.cd_boost});
		cur_cfg = c;
	endtask

	////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] rd_data;
		logic [31:0] pattern;
		void'($urandom(32165));
		cycle_count = 0;
		reset = 1'b1;
		wb_req = '0;
		src = '0;
		cur_cfg = '0;
		test_name = "reset";
		repeat (10) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		repeat (10) @(negedge clk_sys);
		check_value(test_name, 32'd0, 32'(out.valid));
		read_reg(3'd0, rd_data);
		check_value(test_name, 32'd0, rd_data);

		test_name = "register readback";
		repeat (20) begin
			pattern = $urandom;
			write_reg(3'd0, pattern);
			read_reg(3'd0, rd_data);
			check_value(test_name, {28'd0, pattern[3:0]}, rd_data);
			write_reg(3'd4, ~pattern);
			read_reg(3'd0, rd_data);
			check_value("unmapped write", {28'd0, pattern[3:0]}, rd_data);
			read_reg(3'd4, rd_data);
			check_value("unmapped read", 32'd0, rd_data);
		end

		apply_config('{cd_boost: 1'b0, adpcm_boost: 1'b0, master: 2'd0});
		run_random("all options off", 300, 1'b0);
		apply_config('{cd_boost: 1'b1, adpcm_boost: 1'b0, master: 2'd0});
		test_name = "cd boost";
		drive_extremes();
		run_random("cd boost", 148, 1'b0);
		apply_config('{cd_boost: 1'b0, adpcm_boost: 1'b1, master: 2'd0});
		test_name = "adpcm boost";
		drive_extremes();
		run_random("adpcm boost", 148, 1'b0);
		apply_config('{cd_boost: 1'b1, adpcm_boost: 1'b1, master: 2'd0});
		test_name = "cd and adpcm boost";
		drive_extremes();
		run_random("cd and adpcm boost", 148, 1'b0);

		apply_config('{cd_boost: 1'b1, adpcm_boost: 1'b0, master: 2'd1});
		test_name = "2x curve";
		drive_knees();
		run_random("2x curve", 142, 1'b0);
		apply_config('{cd_boost: 1'b1, adpcm_boost: 1'b0, master: 2'd3});
		test_name = "4x curve";
		drive_knees();
		run_random("4x curve", 142, 1'b0);

		apply_config('{cd_boost: 1'b0, adpcm_boost: 1'b1, master: 2'd2});
		run_random("sparse valid", 200, 1'b1);

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hw/audio_pkg.sv
hw/audio_cfg_regs.sv
hw/audio_presum.sv
hw/audio_compressor.sv
hw/audio_mix_top.sv
bench/audio_mix_tb.sv

// File: hw/audio_cfg_regs.sv
// Single register at address 0; other addresses ack, ignore writes and read zero; ack after one edge
`default_nettype none

module audio_cfg_regs (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  audio_pkg::wb_req_t   wb_req,
	output audio_pkg::wb_rsp_t   wb_rsp,
	output audio_pkg::audio_cfg_t cfg
);

	import audio_pkg::*;

	audio_cfg_t  cfg_q;
	logic        ack_q;
	logic [31:0] dat_r_q;

	logic        req;
	logic        hit;
	logic [31:0] cfg_word;

	////////////////////////////////////////////////////////////////////
	// Bus decode
	////////////////////////////////////////////////////////////////////

	// New request only, the held stb during ack is not a second access
	assign req = wb_req.cyc & wb_req.stb & ~ack_q;
	assign hit = (wb_req.adr == CFG_ADDR);

	always_comb begin
		cfg_word = '0;
		cfg_word[CFG_CD_BOOST_BIT] = cfg_q.cd_boost;
		cfg_word[CFG_ADPCM_BOOST_BIT] = cfg_q.adpcm_boost;
		cfg_word[CFG_MASTER_MSB:CFG_MASTER_LSB] = cfg_q.master;
	end

	////////////////////////////////////////////////////////////////////
	// Acknowledge and option register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q <= 1'b0;
			cfg_q <= '0;
		end else begin
			ack_q <= req;
			if (req && wb_req.we && hit) begin
				cfg_q.cd_boost <= wb_req.dat_w[CFG_CD_BOOST_BIT];
				cfg_q.adpcm_boost <= wb_req.dat_w[CFG_ADPCM_BOOST_BIT];
				cfg_q.master <= wb_req.dat_w[CFG_MASTER_MSB:CFG_MASTER_LSB];
			end
		end
	end

	// Read data captured on the same edge that raises ack
	always_ff @(posedge clk_sys) begin
		if (req) begin
			dat_r_q <= hit ? cfg_word : 32'd0;
		end
	end

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.dat_r = dat_r_q;
	assign cfg          = cfg_q;

endmodule

`default_nettype wire

// File: hw/audio_compressor.sv
// One-cycle latency; parameters must keep (32768 - knee) / factor + offset within 16 bits
`default_nettype none

module audio_compressor #(
	parameter int COMP2_FACTOR = 4,
	parameter int COMP2_GAIN   = 2,
	parameter int COMP4_FACTOR = 8,
	parameter int COMP4_GAIN   = 4
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  audio_pkg::sum_frame_t  sum,
	input  audio_pkg::boost_mode_t master,
	output audio_pkg::out_frame_t  out
);

	import audio_pkg::*;

	////////////////////////////////////////////////////////////////////
	// Curve constants
	////////////////////////////////////////////////////////////////////

	// Knee rounded up, 14043 and 7399 with the default curves
	localparam int COMP2_X = ((32767 * (COMP2_FACTOR - 1) - 1)
		/ (COMP2_FACTOR * COMP2_GAIN - 1)) + 1;
	localparam int COMP2_B = COMP2_X * COMP2_GAIN;

	localparam int COMP4_X = ((32767 * (COMP4_FACTOR - 1) - 1)
		/ (COMP4_FACTOR * COMP4_GAIN - 1)) + 1;
	localparam int COMP4_B = COMP4_X * COMP4_GAIN;

	logic    valid_q;
	sample_t left_q;
	sample_t right_q;

	sample_t base_l;
	sample_t base_r;

	////////////////////////////////////////////////////////////////////
	// Soft knee
	////////////////////////////////////////////////////////////////////

	// Linear gain below the knee, flattened slope above it
	function automatic logic [15:0] apply_curve(input logic [15:0] mag, input int knee,
			input int offs, input int factor, input int gain);
		int m;
		int r;
		m = int'(mag);
		if (m < knee) begin
			r = m * gain;
		end else begin
			r = ((m - knee) / factor) + offs;
		end
		return r[15:0];
	endfunction

	// Sign-magnitude handling around the curve
	function automatic sample_t compress(input sample_t v, input boost_mode_t mode);
		logic [15:0] mag;
		logic [15:0] shaped;
		mag = v[15] ? (~v + 16'd1) : v;
		if (mode == BOOST_2X) begin
			shaped = apply_curve(mag, COMP2_X, COMP2_B, COMP2_FACTOR, COMP2_GAIN);
		end else begin
			shaped = apply_curve(mag, COMP4_X, COMP4_B, COMP4_FACTOR, COMP4_GAIN);
		end
		if (mode == BOOST_OFF) begin
			return v;
		end
		return v[15] ? sample_t'(~(shaped - 16'd1)) : sample_t'(shaped);
	endfunction

	// Upper 16 bits of the 18-bit level
	assign base_l = sample_t'(sum.left[17:2]);
	assign base_r = sample_t'(sum.right[17:2]);

	////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= sum.valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		left_q  <= compress(base_l, master);
		right_q <= compress(base_r, master);
	end

	assign out = '{valid: valid_q, left: left_q, right: right_q};

endmodule

`default_nettype wire

// File: hw/audio_mix_top.sv
// Four-cycle src to out latency, one frame per cycle; change options only with the pipeline empty
`default_nettype none

module audio_mix_top #(
	parameter int COMP2_FACTOR = 4,
	parameter int COMP2_GAIN   = 2,
	parameter int COMP4_FACTOR = 8,
	parameter int COMP4_GAIN   = 4
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  audio_pkg::wb_req_t     wb_req,
	output audio_pkg::wb_rsp_t     wb_rsp,
	input  audio_pkg::src_frame_t  src,
	output audio_pkg::out_frame_t  out
);

	import audio_pkg::*;

	audio_cfg_t cfg;
	sum_frame_t sum_frame;

	////////////////////////////////////////////////////////////////////
	// Host options
	////////////////////////////////////////////////////////////////////

	audio_cfg_regs i_cfg_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.cfg     (cfg)
	);

	////////////////////////////////////////////////////////////////////
	// Mixing chain
	////////////////////////////////////////////////////////////////////

	audio_presum i_presum (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.src         (src),
		.cd_boost    (cfg.cd_boost),
		.adpcm_boost (cfg.adpcm_boost),
		.sum         (sum_frame)
	);

	audio_compressor #(
		.COMP2_FACTOR (COMP2_FACTOR),
		.COMP2_GAIN   (COMP2_GAIN),
		.COMP4_FACTOR (COMP4_FACTOR),
		.COMP4_GAIN   (COMP4_GAIN)
	) i_compressor (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sum     (sum_frame),
		.master  (cfg.master),
		.out     (out)
	);

endmodule

`default_nettype wire

// File: hw/audio_pkg.sv
// Samples are signed two's complement on one clock; the option register sits at byte address 0
`default_nettype none

package audio_pkg;

	// Sample widths along the chain
	typedef logic signed [15:0] sample_t;
	typedef logic signed [16:0] boost_t;
	typedef logic signed [17:0] sum_t;

	// Master compression mode, 2 and 3 both select the 4x curve
	typedef logic [1:0] boost_mode_t;

	localparam boost_mode_t BOOST_OFF = 2'd0;
	localparam boost_mode_t BOOST_2X  = 2'd1;

	typedef struct packed {
		logic        cd_boost;
		logic        adpcm_boost;
		boost_mode_t master;
	} audio_cfg_t;

	// Option register layout
	localparam logic [2:0] CFG_ADDR            = 3'd0;
	localparam int         CFG_CD_BOOST_BIT    = 0;
	localparam int         CFG_ADPCM_BOOST_BIT = 1;
	localparam int         CFG_MASTER_LSB      = 2;
	localparam int         CFG_MASTER_MSB      = 3;

	typedef struct packed {
		logic    valid;
		sample_t cd_left;
		sample_t cd_right;
		sample_t psg_left;
		sample_t psg_right;
		sample_t adpcm;
	} src_frame_t;

	typedef struct packed {
		logic valid;
		sum_t left;
		sum_t right;
	} sum_frame_t;

	typedef struct packed {
		logic    valid;
		sample_t left;
		sample_t right;
	} out_frame_t;

	// Wishbone classic, 32-bit data, byte address
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [31:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: hw/audio_presum.sv
// Three-cycle latency, no back-pressure; option inputs act on frames already in flight
`default_nettype none

module audio_presum (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  audio_pkg::src_frame_t  src,
	input  wire                    cd_boost,
	input  wire                    adpcm_boost,
	output audio_pkg::sum_frame_t  sum
);

	import audio_pkg::*;

	// Stage 1 registers
	logic    valid_1;
	sample_t cd_l_1;
	sample_t cd_r_1;
	sample_t psg_l_1;
	sample_t psg_r_1;
	boost_t  adpcm_1;

	// Stage 2 registers
	logic    valid_2;
	sum_t    pre_l_2;
	sum_t    pre_r_2;

	// Stage 3 registers
	logic    valid_3;
	sum_t    lvl_l_3;
	sum_t    lvl_r_3;

	boost_t  adpcm_boosted;

	////////////////////////////////////////////////////////////////////
	// Per-channel arithmetic
	////////////////////////////////////////////////////////////////////

	// CD twice when boosted, sums wrap at 18 bits
	function automatic sum_t channel_sum(input sample_t cd, input sample_t psg,
			input boost_t adpcm, input logic cd_dbl);
		sum_t cd_x;
		cd_x = sum_t'(cd);
		return cd_x + (cd_dbl ? cd_x : sum_t'(0)) + sum_t'(psg) + sum_t'(adpcm);
	endfunction

	// Five quarters unless CD boost already raised the level
	function automatic sum_t level_scale(input sum_t pre, input logic cd_dbl);
		return cd_dbl ? pre : pre + (pre >>> 2);
	endfunction

	// ADPCM plus a quarter of itself
	assign adpcm_boosted = boost_t'(src.adpcm)
		+ (adpcm_boost ? boost_t'(src.adpcm >>> 2) : boost_t'(0));

	////////////////////////////////////////////////////////////////////
	// Valid pipeline
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_1 <= 1'b0;
			valid_2 <= 1'b0;
			valid_3 <= 1'b0;
		end else begin
			valid_1 <= src.valid;
			valid_2 <= valid_1;
			valid_3 <= valid_2;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Data pipeline
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		cd_l_1  <= src.cd_left;
		cd_r_1  <= src.cd_right;
		psg_l_1 <= src.psg_left;
		psg_r_1 <= src.psg_right;
		adpcm_1 <= adpcm_boosted;

		pre_l_2 <= channel_sum(cd_l_1, psg_l_1, adpcm_1, cd_boost);
		pre_r_2 <= channel_sum(cd_r_1, psg_r_1, adpcm_1, cd_boost);

		lvl_l_3 <= level_scale(pre_l_2, cd_boost);
		lvl_r_3 <= level_scale(pre_r_2, cd_boost);
	end

	assign sum = '{valid: valid_3, left: lvl_l_3, right: lvl_r_3};

endmodule

`default_nettype wire
